// File: compile.f
source/tx_dma_pkg.sv
source/tx_request_arbiter.sv
source/tx_request_queue.sv
source/l2_read_issuer.sv
source/rdata_aligner.sv
source/tx_dma_channels.sv
tb/tx_dma_properties.sv
tb/tb_tx_dma_channels.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the tx dma testbench with verilator, pass is read from the log
set -e
cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG=sim.log

rm -rf "$BUILD_DIR" "$LOG"
verilator --binary --assert -Wno-fatal --top-module tb_tx_dma_channels \
    --Mdir "$BUILD_DIR" -o tb_sim -f compile.f
"./$BUILD_DIR/tb_sim" +verilator+error+limit+1000 | tee "$LOG"

if grep -qx "All checks passed" "$LOG"; then
    echo "simulation result: pass"
else
    echo "simulation result: fail"
    exit 1
fi

// File: tb/tb_tx_dma_channels.sv
////////////////////
// l2 model answers one cycle after each accepted read, each word is a hash of its address
// size 3 is never requested
////////////////////
module tb_tx_dma_channels;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int N               = tx_dma_pkg::N_CHANNELS;
    localparam int TOTAL_ITEMS     = 76;   // aligned 12, unaligned 16, concurrent 32, hold 16
    localparam int WATCHDOG_CYCLES = TOTAL_ITEMS * 25 + 100;

    logic                                             clk_i;
    logic                                             rstn_i;
    tx_dma_pkg::ch_mask_t                             ext_req_i;
    tx_dma_pkg::tx_cmd_t [tx_dma_pkg::N_CHANNELS-1:0] ext_cmd_i;
    tx_dma_pkg::ch_mask_t                             ext_gnt_o;
    tx_dma_pkg::ch_mask_t                             ext_ready_i;
    tx_dma_pkg::ch_mask_t                             ext_valid_o;
    tx_dma_pkg::word_t                                ext_data_o;
    logic                                             l2_req_o;
    logic                                             l2_gnt_i;
    tx_dma_pkg::bus_addr_t                            l2_addr_o;
    tx_dma_pkg::word_t                                l2_rdata_i;
    logic                                             l2_rvalid_i;

    integer               seed = 32'h41a0;
    int                   errors = 0;
    int unsigned          assert_fails;
    string                test_name;
    tx_dma_pkg::tx_item_t issue_q[$];   // granted, reads still due
    tx_dma_pkg::tx_item_t resp_q[$];    // granted, response still due
    logic                 second_pending = 1'b0;
    int                   req_count[N] = '{default: 0};
    int                   gnt_count[N] = '{default: 0};
    int                   resp_count[N] = '{default: 0};
    logic [N-1:0]         passed[N] = '{default: '0};   // [j][c] c won while j waited

    tx_dma_channels tx_dma_channels_i (.*);

    function automatic tx_dma_pkg::word_t mem_word(input tx_dma_pkg::bus_addr_t a);
        return (a * 32'h9E37_79B1) ^ {a[15:0], a[31:16]};
    endfunction

    function automatic tx_dma_pkg::bus_addr_t compose_addr(input tx_dma_pkg::dest_t d,
                                                           input tx_dma_pkg::l2_offset_t off);
        case (d)
            2'd1:    return {12'h1A1, off[19:2], 2'b00};
            2'd2:    return {8'h10, 4'h0, off[19:2], 2'b00};
            default: return {8'h1C, 4'h0, off[19:2], 2'b00};   // dest 0 and 3
        endcase
    endfunction

    function automatic logic is_split(input tx_dma_pkg::tx_cmd_t c);
        return ((c.datasize == 2'd1) && (c.offset[1:0] == 2'd3)) ||
               ((c.datasize == 2'd2) && (c.offset[1:0] != 2'd0));
    endfunction

    // little-endian bytes from the offset on, zero-extended
    function automatic tx_dma_pkg::word_t expect_data(input tx_dma_pkg::tx_cmd_t c);
        tx_dma_pkg::word_t      r;
        tx_dma_pkg::word_t      w;
        tx_dma_pkg::l2_offset_t p;
        int                     nbytes;
        r      = '0;
        nbytes = (c.datasize == 2'd0) ? 1 : (c.datasize == 2'd1) ? 2 : 4;
        for (int i = 0; i < nbytes; i++)
        begin
            p = c.offset + tx_dma_pkg::l2_offset_t'(i);
            w = mem_word(compose_addr(c.dest, p));
            r[i*8 +: 8] = w[{p[1:0], 3'b000} +: 8];
        end
        return r;
    endfunction

    function automatic tx_dma_pkg::tx_cmd_t make_cmd(input int size, input int lane, input int dest);
        tx_dma_pkg::tx_cmd_t c;
        c.offset      = tx_dma_pkg::l2_offset_t'($random(seed));
        c.offset[1:0] = 2'(lane);
        c.datasize    = 2'(size);
        c.dest        = 2'(dest);
        return c;
    endfunction

    task automatic check_value(input string what, input tx_dma_pkg::word_t exp,
                               input tx_dma_pkg::word_t act);
        if (exp !== act)
        begin
            errors++;
            $display("mismatch %s %s expected %h actual %h", test_name, what, exp, act);
        end
    endtask

    // called 1 ns after an edge, returns 1 ns after the grant edge
    task automatic channel_read(input int ch, input tx_dma_pkg::tx_cmd_t cmd);
        ext_cmd_i[ch] = cmd;
        ext_req_i[ch] = 1'b1;
        req_count[ch]++;
        do
            @(posedge clk_i);
        while (!ext_gnt_o[ch]);
        #1;
        ext_req_i[ch] = 1'b0;
    endtask

    task automatic channel_burst(input int ch, input int n);
        for (int i = 0; i < n; i++)
            channel_read(ch, make_cmd({$random(seed)} % 3, $random(seed), $random(seed)));
    endtask

    task automatic wait_drain();
        while (resp_q.size() != 0)
            @(posedge clk_i);
        repeat (4) @(posedge clk_i);
        #1;
    endtask

    initial
    begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    ////////////////////
    // l2 memory model
    ////////////////////
    always @(posedge clk_i)
    begin
        logic                  hit;
        tx_dma_pkg::bus_addr_t addr;
        hit  = l2_req_o && l2_gnt_i;
        addr = l2_addr_o;
        #1;
        l2_rvalid_i = hit;
        l2_rdata_i  = hit ? mem_word(addr) : '0;
        l2_gnt_i    = 1'($random(seed));
    end

    ////////////////////
    // scoreboard
    ////////////////////
    always @(posedge clk_i)
    begin
        tx_dma_pkg::tx_item_t it;
        for (int c = 0; c < N; c++)
        begin
            if (ext_valid_o[c])
                resp_count[c]++;
            if (ext_gnt_o[c])
            begin
                gnt_count[c]++;
                for (int j = 0; j < N; j++)
                begin
                    if (j != c && ext_req_i[j] && passed[j][c])
                    begin
                        errors++;
                        $display("%s: channel %0d granted twice while channel %0d waited",
                                 test_name, c, j);
                    end
                    if (j != c && ext_req_i[j])
                        passed[j][c] = 1'b1;
                end
                passed[c] = '0;
                it.cmd    = ext_cmd_i[c];
                it.ch     = tx_dma_pkg::ch_id_t'(c);
                issue_q.push_back(it);
                resp_q.push_back(it);
            end
        end
        if (l2_req_o && l2_gnt_i)
        begin
            if (issue_q.size() == 0)
            begin
                errors++;
                $display("%s: l2 read accepted with no granted request", test_name);
            end
            else
            begin
                it = issue_q[0];
                check_value("l2_addr", compose_addr(it.cmd.dest,
                            it.cmd.offset + (second_pending ? 20'd4 : 20'd0)), l2_addr_o);
                second_pending = is_split(it.cmd) && !second_pending;
                if (!second_pending)
                    it = issue_q.pop_front();
            end
        end
        if (ext_valid_o != '0)
        begin
            if (resp_q.size() == 0)
            begin
                errors++;
                $display("%s: response with no outstanding request", test_name);
            end
            else
            begin
                it = resp_q.pop_front();
                check_value("ext_valid", tx_dma_pkg::word_t'(tx_dma_pkg::ch_mask_t'(1) << it.ch),
                            tx_dma_pkg::word_t'(ext_valid_o));
                check_value("ext_data", expect_data(it.cmd), ext_data_o);
            end
        end
    end

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_i);
        $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Checks failed");
        $finish;
    end

    initial
    begin
        rstn_i      = 1'b0;
        ext_req_i   = '0;
        ext_cmd_i   = '0;
        ext_ready_i = '1;
        l2_gnt_i    = 1'b0;
        l2_rdata_i  = '0;
        l2_rvalid_i = 1'b0;
        test_name   = "reset";
        repeat (5) @(posedge clk_i);
        #1 rstn_i = 1'b1;
        repeat (2) @(posedge clk_i);
        #1;

        test_name = "aligned";
        for (int ch = 0; ch < N; ch++)
            for (int size = 0; size < 3; size++)
                channel_read(ch, make_cmd(size, (size == 0) ? ch : (size == 1) ? ch % 3 : 0,
                                          (ch + size) % 4));
        wait_drain();

        test_name = "unaligned";   // half at lane 3, word at lanes 1 to 3
        for (int ch = 0; ch < N; ch++)
            for (int k = 0; k < 4; k++)
                channel_read(ch, make_cmd((k == 0) ? 1 : 2, (k == 0) ? 3 : k, (ch + k) % 4));
        wait_drain();

        test_name = "concurrent";
        fork
            channel_burst(0, 8);
            channel_burst(1, 8);
            channel_burst(2, 8);
            channel_burst(3, 8);
        join
        wait_drain();

        test_name   = "backpressure";
        ext_ready_i = 4'b1101;   // channel 1 stalls its responses
        fork
            channel_burst(0, 4);
            channel_burst(1, 4);
            channel_burst(2, 4);
            channel_burst(3, 4);
        join
        wait_drain();
        ext_ready_i = '1;

        test_name = "totals";
        for (int c = 0; c < N; c++)
        begin
            check_value("grant count", req_count[c], gnt_count[c]);
            check_value("response count", req_count[c], resp_count[c]);
        end
        assert_fails = tx_dma_channels_i.tx_dma_properties_i.fail_count;
        $display("closing: %0d data errors, %0d assertion failures", errors, assert_fails);
        if (errors == 0 && assert_fails == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

// File: tb/tx_dma_properties.sv
////////////////////
// protocol checks on the top-level ports, bound into tx_dma_channels
// fail_count is read back by the testbench for its closing line
////////////////////
module tx_dma_properties
(
    input logic                  clk_i,
    input logic                  rstn_i,
    input tx_dma_pkg::ch_mask_t  ext_gnt_o,
    input tx_dma_pkg::ch_mask_t  ext_ready_i,
    input tx_dma_pkg::ch_mask_t  ext_valid_o,
    input logic                  l2_req_o,
    input tx_dma_pkg::bus_addr_t l2_addr_o
);
    timeunit 1ns;
    timeprecision 100ps;

    int unsigned fail_count = 0;
    logic        quiet;
    logic        prefix_ok;

    assign quiet = !l2_req_o && (ext_gnt_o == '0) && (ext_valid_o == '0);

    // one of the three regions
    assign prefix_ok = (l2_addr_o[31:24] == tx_dma_pkg::PREFIX_L2) ||
                       (l2_addr_o[31:20] == tx_dma_pkg::PREFIX_PERIPH) ||
                       (l2_addr_o[31:24] == tx_dma_pkg::PREFIX_ROM);

    ////////////////////
    // reset
    ////////////////////
    reset_quiet_a: assert property (@(posedge clk_i) (!rstn_i || $rose(rstn_i)) |-> quiet)
    else
    begin
        fail_count++;
        $error("l2_req_o, ext_gnt_o or ext_valid_o high during or right after reset");
    end

    ////////////////////
    // address and routing
    ////////////////////
    l2_addr_a: assert property (@(posedge clk_i) disable iff (!rstn_i)
        l2_req_o |-> prefix_ok && (l2_addr_o[1:0] == 2'b00))
    else
    begin
        fail_count++;
        $error("l2_addr_o has a bad region prefix or nonzero lane bits");
    end

    gnt_onehot_a: assert property (@(posedge clk_i) disable iff (!rstn_i) $onehot0(ext_gnt_o))
    else
    begin
        fail_count++;
        $error("more than one grant bit set");
    end

    valid_onehot_a: assert property (@(posedge clk_i) disable iff (!rstn_i) $onehot0(ext_valid_o))
    else
    begin
        fail_count++;
        $error("more than one valid bit set");
    end

    // owner not ready keeps l2 quiet
    hold_a: assert property (@(posedge clk_i) disable iff (!rstn_i)
        ((ext_valid_o & ~ext_ready_i) != '0) |-> !l2_req_o)
    else
    begin
        fail_count++;
        $error("l2_req_o high while the response owner is not ready");
    end

endmodule

bind tx_dma_channels tx_dma_properties tx_dma_properties_i (.*);

// File: source/tx_dma_channels.sv
////////////////////
// dma read path for externally addressed channels, 32-bit l2 only
// l2 must answer one cycle after each grant
////////////////////
module tx_dma_channels
(
    input  logic                                             clk_i,
    input  logic                                             rstn_i,

    input  tx_dma_pkg::ch_mask_t                             ext_req_i,
    input  tx_dma_pkg::tx_cmd_t [tx_dma_pkg::N_CHANNELS-1:0] ext_cmd_i,
    output tx_dma_pkg::ch_mask_t                             ext_gnt_o,
    input  tx_dma_pkg::ch_mask_t                             ext_ready_i,
    output tx_dma_pkg::ch_mask_t                             ext_valid_o,
    output tx_dma_pkg::word_t                                ext_data_o,

    output logic                                             l2_req_o,
    input  logic                                             l2_gnt_i,
    output tx_dma_pkg::bus_addr_t                            l2_addr_o,
    input  tx_dma_pkg::word_t                                l2_rdata_i,
    input  logic                                             l2_rvalid_i
);

    logic                 slot_valid;
    tx_dma_pkg::tx_item_t slot_item;
    logic                 queue_ready;
    logic                 head_valid;
    tx_dma_pkg::tx_item_t head_item;
    logic                 pop;
    logic                 hold;
    logic                 beat_valid;
    tx_dma_pkg::beat_t    beat;

    tx_request_arbiter tx_request_arbiter_i (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .req_i         (ext_req_i),
        .cmd_i         (ext_cmd_i),
        .queue_ready_i (queue_ready),
        .gnt_o         (ext_gnt_o),
        .slot_valid_o  (slot_valid),
        .slot_o        (slot_item)
    );

    tx_request_queue tx_request_queue_i (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .push_i       (slot_valid),   // taken only while ready
        .item_i       (slot_item),
        .ready_o      (queue_ready),
        .pop_i        (pop),
        .head_valid_o (head_valid),
        .head_o       (head_item)
    );

    l2_read_issuer l2_read_issuer_i (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .head_valid_i (head_valid),
        .head_i       (head_item),
        .hold_i       (hold),
        .l2_gnt_i     (l2_gnt_i),
        .pop_o        (pop),
        .l2_req_o     (l2_req_o),
        .l2_addr_o    (l2_addr_o),
        .beat_valid_o (beat_valid),
        .beat_o       (beat)
    );

    rdata_aligner rdata_aligner_i (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .beat_valid_i (beat_valid),
        .beat_i       (beat),
        .l2_rvalid_i  (l2_rvalid_i),
        .l2_rdata_i   (l2_rdata_i),
        .ext_ready_i  (ext_ready_i),
        .ext_valid_o  (ext_valid_o),
        .ext_data_o   (ext_data_o),
        .hold_o       (hold)
    );

endmodule

// File: source/rdata_aligner.sv
////////////////////
// assumes rvalid exactly one cycle after each accepted read, in order
////////////////////
module rdata_aligner
(
    input  logic                 clk_i,
    input  logic                 rstn_i,
    input  logic                 beat_valid_i,
    input  tx_dma_pkg::beat_t    beat_i,
    input  logic                 l2_rvalid_i,
    input  tx_dma_pkg::word_t    l2_rdata_i,
    input  tx_dma_pkg::ch_mask_t ext_ready_i,
    output tx_dma_pkg::ch_mask_t ext_valid_o,
    output tx_dma_pkg::word_t    ext_data_o,
    output logic                 hold_o
);

    tx_dma_pkg::beat_t  beat_q;       // lines up with rvalid
    logic               beat_vld_q;
    tx_dma_pkg::word_t  merge_q;      // upper lanes of the first word
    tx_dma_pkg::word_t  data_q;
    tx_dma_pkg::ch_id_t ch_q;
    logic               valid_q;

    tx_dma_pkg::word_t  lo_part;
    tx_dma_pkg::word_t  merged;
    tx_dma_pkg::word_t  size_mask;
    tx_dma_pkg::word_t  result;
    logic [4:0]         shift_lo;
    logic [5:0]         shift_hi;
    logic               take_first;
    logic               take_last;

    assign take_first = l2_rvalid_i && beat_vld_q && beat_q.first_half;
    assign take_last  = l2_rvalid_i && beat_vld_q && !beat_q.first_half;

    ////////////////////
    // extract and merge
    ////////////////////
    always_comb
    begin
        shift_lo = {beat_q.lane, 3'b000};
        shift_hi = {3'd4 - {1'b0, beat_q.lane}, 3'b000};   // bytes taken from word one
        lo_part  = l2_rdata_i >> shift_lo;
        if (beat_q.second_half)
            merged = merge_q | (l2_rdata_i << shift_hi);
        else
            merged = lo_part;
        case (beat_q.datasize)
            tx_dma_pkg::DS_BYTE: size_mask = 32'h0000_00FF;
            tx_dma_pkg::DS_HALF: size_mask = 32'h0000_FFFF;
            default:             size_mask = 32'hFFFF_FFFF;
        endcase
        result = merged & size_mask;   // zero-extend
    end

    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
        begin
            beat_vld_q <= 1'b0;
            valid_q    <= 1'b0;
        end
        else
        begin
            beat_vld_q <= beat_valid_i;
            valid_q    <= take_last;   // single cycle per item
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (beat_valid_i)
            beat_q <= beat_i;
        if (take_first)
            merge_q <= lo_part;
        if (take_last)
        begin
            data_q <= result;
            ch_q   <= beat_q.ch;
        end
    end

    ////////////////////
    // response routing
    ////////////////////
    assign ext_valid_o = valid_q ? (tx_dma_pkg::ch_mask_t'(1) << ch_q) : '0;
    assign ext_data_o  = data_q;

    // owner not ready, keep new reads off l2
    assign hold_o = valid_q && !ext_ready_i[ch_q];

endmodule

// File: source/l2_read_issuer.sv
////////////////////
// issues word reads to l2, an unaligned item takes two reads
// the item leaves the queue only after its last accepted read
////////////////////
module l2_read_issuer
(
    input  logic                  clk_i,
    input  logic                  rstn_i,
    input  logic                  head_valid_i,
    input  tx_dma_pkg::tx_item_t  head_i,
    input  logic                  hold_i,
    input  logic                  l2_gnt_i,
    output logic                  pop_o,
    output logic                  l2_req_o,
    output tx_dma_pkg::bus_addr_t l2_addr_o,
    output logic                  beat_valid_o,
    output tx_dma_pkg::beat_t     beat_o
);

    tx_dma_pkg::issue_state_t state_q;
    tx_dma_pkg::issue_state_t state_d;
    logic [tx_dma_pkg::ALIGN_BITS-1:0] lane;
    logic [tx_dma_pkg::L2_AWIDTH-tx_dma_pkg::ALIGN_BITS-1:0] word_off;
    logic unaligned;
    logic accept;

    assign lane = head_i.cmd.offset[tx_dma_pkg::ALIGN_BITS-1:0];

    // half-word crossing lane 3, or any word off lane 0
    assign unaligned = ((head_i.cmd.datasize == tx_dma_pkg::DS_HALF) && (lane == 2'd3)) ||
                       ((head_i.cmd.datasize == tx_dma_pkg::DS_WORD) && (lane != 2'd0));

    assign l2_req_o = head_valid_i && !hold_i;
    assign accept   = l2_req_o && l2_gnt_i;

    ////////////////////
    // address
    ////////////////////
    always_comb
    begin
        word_off = head_i.cmd.offset[tx_dma_pkg::L2_AWIDTH-1:tx_dma_pkg::ALIGN_BITS];
        if (state_q == tx_dma_pkg::ISSUE_SECOND)
            word_off = word_off + 1'b1;   // next word of a split read
        l2_addr_o = tx_dma_pkg::bus_addr_t'({word_off, {tx_dma_pkg::ALIGN_BITS{1'b0}}});
        case (head_i.cmd.dest)
            tx_dma_pkg::DEST_PERIPH: l2_addr_o[31:20] = tx_dma_pkg::PREFIX_PERIPH;
            tx_dma_pkg::DEST_ROM:    l2_addr_o[31:24] = tx_dma_pkg::PREFIX_ROM;
            default:                 l2_addr_o[31:24] = tx_dma_pkg::PREFIX_L2;
        endcase
    end

    ////////////////////
    // split fsm
    ////////////////////
    always_comb
    begin
        state_d = state_q;
        pop_o   = 1'b0;
        case (state_q)
            tx_dma_pkg::ISSUE_IDLE:
            begin
                if (accept && unaligned)
                    state_d = tx_dma_pkg::ISSUE_SECOND;
                else
                    pop_o = accept;
            end
            default:
            begin
                pop_o = accept;
                if (accept)
                    state_d = tx_dma_pkg::ISSUE_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
            state_q <= tx_dma_pkg::ISSUE_IDLE;
        else
            state_q <= state_d;
    end

    assign beat_valid_o       = accept;
    assign beat_o.ch          = head_i.ch;
    assign beat_o.datasize    = head_i.cmd.datasize;
    assign beat_o.lane        = lane;
    assign beat_o.first_half  = (state_q == tx_dma_pkg::ISSUE_IDLE) && unaligned;
    assign beat_o.second_half = (state_q == tx_dma_pkg::ISSUE_SECOND);

endmodule

// File: source/tx_request_queue.sv
////////////////////
// four entry fifo of read commands, push is ignored while full
////////////////////
module tx_request_queue
(
    input  logic                 clk_i,
    input  logic                 rstn_i,
    input  logic                 push_i,
    input  tx_dma_pkg::tx_item_t item_i,
    output logic                 ready_o,
    input  logic                 pop_i,
    output logic                 head_valid_o,
    output tx_dma_pkg::tx_item_t head_o
);

    tx_dma_pkg::tx_item_t                        mem_q [tx_dma_pkg::QUEUE_DEPTH];
    logic [$clog2(tx_dma_pkg::QUEUE_DEPTH)-1:0]  wr_ptr_q;
    logic [$clog2(tx_dma_pkg::QUEUE_DEPTH)-1:0]  rd_ptr_q;
    logic [$clog2(tx_dma_pkg::QUEUE_DEPTH+1)-1:0] count_q;
    logic                                        push_ok;
    logic                                        pop_ok;

    assign ready_o      = (count_q != tx_dma_pkg::QUEUE_DEPTH);
    assign head_valid_o = (count_q != '0);
    assign head_o       = mem_q[rd_ptr_q];

    assign push_ok = push_i && ready_o;
    assign pop_ok  = pop_i && head_valid_o;

    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
        begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end
        else
        begin
            if (push_ok)
                wr_ptr_q <= wr_ptr_q + 1'b1;   // wraps at depth
            if (pop_ok)
                rd_ptr_q <= rd_ptr_q + 1'b1;
            case ({push_ok, pop_ok})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;   // none or both
            endcase
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (push_ok)
            mem_q[wr_ptr_q] <= item_i;
    end

endmodule

// File: source/tx_request_arbiter.sv
////////////////////
// round-robin pick among channel requests, one grant per cycle
// a channel must hold req and cmd until its grant pulse
////////////////////
module tx_request_arbiter
(
    input  logic                                          clk_i,
    input  logic                                          rstn_i,
    input  tx_dma_pkg::ch_mask_t                          req_i,
    input  tx_dma_pkg::tx_cmd_t [tx_dma_pkg::N_CHANNELS-1:0] cmd_i,
    input  logic                                          queue_ready_i,
    output tx_dma_pkg::ch_mask_t                          gnt_o,
    output logic                                          slot_valid_o,
    output tx_dma_pkg::tx_item_t                          slot_o
);

    tx_dma_pkg::ch_id_t   rr_ptr_q;   // search starts here
    tx_dma_pkg::ch_id_t   win_id;
    tx_dma_pkg::ch_id_t   idx;
    tx_dma_pkg::tx_item_t slot_q;
    logic                 found;
    logic                 load_en;
    logic                 slot_valid_q;

    ////////////////////
    // winner search
    ////////////////////
    always_comb
    begin
        found  = 1'b0;
        win_id = rr_ptr_q;
        idx    = rr_ptr_q;
        for (int i = 0; i < tx_dma_pkg::N_CHANNELS; i++)
        begin
            idx = rr_ptr_q + tx_dma_pkg::ch_id_t'(i);
            if (!found && req_i[idx])
            begin
                found  = 1'b1;
                win_id = idx;
            end
        end
    end

    // slot is free or drains into the queue this cycle
    assign load_en = !slot_valid_q || queue_ready_i;

    assign gnt_o = (load_en && found) ? (tx_dma_pkg::ch_mask_t'(1) << win_id) : '0;

    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
        begin
            rr_ptr_q     <= '0;
            slot_valid_q <= 1'b0;
        end
        else if (load_en)
        begin
            slot_valid_q <= found;
            if (found)
                rr_ptr_q <= win_id + 1'b1;   // winner goes last next time
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (load_en && found)
        begin
            slot_q.cmd <= cmd_i[win_id];
            slot_q.ch  <= win_id;
        end
    end

    assign slot_valid_o = slot_valid_q;
    assign slot_o       = slot_q;

endmodule

// File: source/tx_dma_pkg.sv
////////////////////
// widths, encodings and shared types of the tx dma read path
// l2 data is 32 bits only, size 3 is reserved and read as a word
////////////////////
package tx_dma_pkg;

    localparam int N_CHANNELS  = 4;
    localparam int CH_ID_W     = 2;
    localparam int L2_AWIDTH   = 20;   // byte offset seen by a channel
    localparam int DATA_W      = 32;
    localparam int ALIGN_BITS  = 2;
    localparam int QUEUE_DEPTH = 4;

    // upper address bits per region
    localparam logic [7:0]  PREFIX_L2     = 8'h1C;
    localparam logic [11:0] PREFIX_PERIPH = 12'h1A1;
    localparam logic [7:0]  PREFIX_ROM    = 8'h10;

    localparam logic [1:0] DS_BYTE = 2'd0;
    localparam logic [1:0] DS_HALF = 2'd1;
    localparam logic [1:0] DS_WORD = 2'd2;

    localparam logic [1:0] DEST_L2     = 2'd0;
    localparam logic [1:0] DEST_PERIPH = 2'd1;
    localparam logic [1:0] DEST_ROM    = 2'd2;   // 3 maps back to l2

    typedef logic [N_CHANNELS-1:0] ch_mask_t;
    typedef logic [CH_ID_W-1:0]    ch_id_t;
    typedef logic [L2_AWIDTH-1:0]  l2_offset_t;
    typedef logic [31:0]           bus_addr_t;
    typedef logic [DATA_W-1:0]     word_t;
    typedef logic [1:0]            datasize_t;
    typedef logic [1:0]            dest_t;

    typedef struct packed {
        l2_offset_t offset;
        datasize_t  datasize;
        dest_t      dest;
    } tx_cmd_t;

    typedef struct packed {
        tx_cmd_t cmd;
        ch_id_t  ch;
    } tx_item_t;

    // one per accepted l2 read
    typedef struct packed {
        ch_id_t                ch;
        datasize_t             datasize;
        logic [ALIGN_BITS-1:0] lane;
        logic                  first_half;   // low part of a split read
        logic                  second_half;  // closing part of a split read
    } beat_t;

    typedef enum logic {ISSUE_IDLE, ISSUE_SECOND} issue_state_t;

endpackage
